// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release just after an edge so the first idle cycle is clean
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/fpu_lane_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_lane_settings.svh"

module fpu_lane_tb
  import fpu_lane_pkg::*;
();

  // about 150 cycles of stimulus, four times that as the limit
  localparam int MAX_CYCLES = 600;

  localparam logic [7:0] OPC_AND    = `FPL_OPC_LOGIC;
  localparam logic [7:0] OPC_OR     = `FPL_OPC_LOGIC + 8'd1;
  localparam logic [7:0] OPC_XOR    = `FPL_OPC_LOGIC + 8'd2;
  localparam logic [7:0] OPC_ANDNOT = `FPL_OPC_LOGIC + 8'd3;
  localparam logic [7:0] OPC_PERM   = `FPL_OPC_PERM;

  typedef struct packed {
    logic [31:0]            due;
    operand_t               result;
    logic [`FPL_RTAG_W-1:0] tag;
    logic                   inv;
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   en;
  op_t                    op;
  operand_t               reg_a;
  operand_t               reg_b;
  fwd_sel_t               fwd_now_a;
  fwd_sel_t               fwd_old_a;
  fwd_sel_t               fwd_now_b;
  fwd_sel_t               fwd_old_b;
  operand_t               bus_cur [`FPL_NFWD];
  operand_t               bus_prev [`FPL_NFWD];
  logic [`FPL_RTAG_W-1:0] ret_tag;
  logic [31:0]            fpcsr;
  operand_t               result;
  logic                   ret_en;
  ret_code_t              ret_code;

  expect_t   exp_q [$];
  logic      exp_ret_en = 1'b0;
  operand_t  exp_result = '0;
  ret_code_t exp_code   = '0;
  int        cyc        = 0;
  integer    seed;
  string     test_name  = "reset";

  clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) clocks (.clk(clk), .rst(rst));

  fpu_lane DUT (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .op        (op),
    .reg_a     (reg_a),
    .reg_b     (reg_b),
    .fwd_now_a (fwd_now_a),
    .fwd_old_a (fwd_old_a),
    .fwd_now_b (fwd_now_b),
    .fwd_old_b (fwd_old_b),
    .fwd_bus0  (bus_cur[0]),
    .fwd_bus1  (bus_cur[1]),
    .fwd_bus2  (bus_cur[2]),
    .fwd_bus3  (bus_cur[3]),
    .ret_tag   (ret_tag),
    .fpcsr     (fpcsr),
    .result    (result),
    .ret_en    (ret_en),
    .ret_code  (ret_code)
  );

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic operand_t rand_operand();
    logic [95:0] raw;
    raw = {rand_word(), rand_word(), rand_word()};
    return raw[`FPL_DATA_W-1:0];
  endfunction

  function automatic fwd_sel_t one_hot(int idx);
    fwd_sel_t s;
    s = '0;
    s[idx % `FPL_NFWD] = 1'b1;
    return s;
  endfunction

  function automatic op_t make_op(logic [7:0] opc, logic [3:0] mods);
    op_t o;
    o = '0;
    o.opcode    = opc;
    o.lo_from_a = mods[0];
    o.hi_from_a = mods[1];
    o.swap      = mods[2];
    o.dup       = mods[3];
    return o;
  endfunction

  // bus of this cycle first, then last cycle's bus, else the register
  function automatic operand_t pick_operand(operand_t reg_val, fwd_sel_t now_sel,
                                            fwd_sel_t old_sel);
    operand_t v;
    v = reg_val;
    for (int i = 0; i < `FPL_NFWD; i++) begin
      if (now_sel[i]) begin
        v = bus_cur[i];
      end else if (old_sel[i] && now_sel == '0) begin
        v = bus_prev[i];
      end
    end
    return v;
  endfunction

  function automatic logic is_undefined(logic [7:0] opc);
    return !(opc inside {OPC_AND, OPC_OR, OPC_XOR, OPC_ANDNOT, OPC_PERM});
  endfunction

  function automatic operand_t expected_result(op_t o, operand_t a, operand_t b);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] t;
    operand_t    r;
    lo = o.lo_from_a ? a[31:0] : b[31:0];
    hi = o.hi_from_a ? a[63:32] : b[63:32];
    if (o.swap) begin
      t  = lo;
      lo = hi;
      hi = t;
    end
    if (o.dup) begin
      hi = lo;
    end
    case (o.opcode)
      OPC_AND:    r = {a[67:64], a[63:0] & b[63:0]};
      OPC_OR:     r = {a[67:64], a[63:0] | b[63:0]};
      OPC_XOR:    r = {a[67:64], a[63:0] ^ b[63:0]};
      OPC_ANDNOT: r = {a[67:64], a[63:0] & ~b[63:0]};
      OPC_PERM:   r = {a[67:64], hi, lo};
      default:    r = '0;
    endcase
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [67:0] expv,
                                 input logic [67:0] actv);
    $display("ERROR %s: %s expected %h, actual %h", test_name, what, expv, actv);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s mismatch", what);
  endtask

  // new bus values each cycle, issue inputs dropped
  task automatic next_cycle();
    @(posedge clk);
    #1;
    for (int i = 0; i < `FPL_NFWD; i++) begin
      bus_prev[i] = bus_cur[i];
      bus_cur[i]  = rand_operand();
    end
    en        = 1'b0;
    fwd_now_a = '0;
    fwd_old_a = '0;
    fwd_now_b = '0;
    fwd_old_b = '0;
  endtask

  task automatic issue_op(input op_t o, input fwd_sel_t na, input fwd_sel_t oa,
                          input fwd_sel_t nb, input fwd_sel_t ob);
    expect_t     e;
    logic [31:0] r;
    r         = rand_word();
    en        = 1'b1;
    op        = o;
    reg_a     = rand_operand();
    reg_b     = rand_operand();
    fwd_now_a = na;
    fwd_old_a = oa;
    fwd_now_b = nb;
    fwd_old_b = ob;
    ret_tag   = r[`FPL_RTAG_W-1:0];
    e.due     = cyc + 2;
    e.result  = expected_result(o, pick_operand(reg_a, na, oa), pick_operand(reg_b, nb, ob));
    e.tag     = ret_tag;
    e.inv     = is_undefined(o.opcode);
    exp_q.push_back(e);
  endtask

  task automatic random_select(output fwd_sel_t now_sel, output fwd_sel_t old_sel);
    logic [31:0] r;
    r       = rand_word();
    now_sel = '0;
    old_sel = '0;
    case (r[1:0])
      2'd1:    now_sel[r[3:2]] = 1'b1;
      2'd2:    old_sel[r[3:2]] = 1'b1;
      default: ;
    endcase
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  // expected outputs for this cycle, settled well before the negedge checks
  always @(posedge clk) begin : track_expected
    expect_t e;
    #2;
    exp_ret_en = 1'b0;
    exp_result = '0;
    exp_code   = '0;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e                 = exp_q.pop_front();
      exp_ret_en        = 1'b1;
      exp_result        = e.result;
      exp_code.tag      = e.tag;
      exp_code.flags[0] = e.inv;
      exp_code.excpt    = e.inv & fpcsr[`FPL_CSR_INV_EN];
    end
  end

  ret_en_check: assert property (@(negedge clk) disable iff (rst) ret_en == exp_ret_en)
    else report_mismatch("ret_en", {67'd0, exp_ret_en}, {67'd0, ret_en});

  result_check: assert property (@(negedge clk) disable iff (rst) result == exp_result)
    else report_mismatch("result", exp_result, result);

  ret_code_check: assert property (@(negedge clk) disable iff (rst)
                                   !exp_ret_en || ret_code == exp_code)
    else report_mismatch("ret_code", {54'd0, exp_code}, {54'd0, ret_code});

  initial begin
    logic [7:0]  logic_ops [4];
    logic [7:0]  bad_ops [6];
    logic [31:0] r;
    fwd_sel_t    na;
    fwd_sel_t    oa;
    fwd_sel_t    nb;
    fwd_sel_t    ob;

    logic_ops = '{OPC_AND, OPC_OR, OPC_XOR, OPC_ANDNOT};
    bad_ops   = '{8'h00, 8'h3f, 8'h44, 8'h47, 8'h49, 8'hff};
    seed      = 32'hf800_5477;
    en        = 1'b0;
    op        = '0;
    reg_a     = '0;
    reg_b     = '0;
    fwd_now_a = '0;
    fwd_old_a = '0;
    fwd_now_b = '0;
    fwd_old_b = '0;
    ret_tag   = '0;
    fpcsr     = '0;
    for (int i = 0; i < `FPL_NFWD; i++) begin
      bus_cur[i]  = '0;
      bus_prev[i] = '0;
    end

    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end

    test_name = "idle";
    repeat (6) next_cycle();

    test_name = "logic";
    for (int f = 0; f < 4; f++) begin
      repeat (6) begin
        next_cycle();
        r = rand_word();
        issue_op(make_op(logic_ops[f], r[3:0]), '0, '0, '0, '0);
      end
    end
    drain();

    // two passes over every modifier combination
    test_name = "permute";
    for (int c = 0; c < 32; c++) begin
      next_cycle();
      issue_op(make_op(OPC_PERM, 4'(c)), '0, '0, '0, '0);
    end
    drain();

    test_name = "forward";
    for (int i = 0; i < `FPL_NFWD; i++) begin
      next_cycle();
      issue_op(make_op(OPC_XOR, 4'd0), one_hot(i), '0, '0, '0);
      next_cycle();
      issue_op(make_op(OPC_ANDNOT, 4'd0), '0, one_hot(i), '0, one_hot(i + 1));
      next_cycle();
      issue_op(make_op(OPC_PERM, 4'b0001), one_hot(i + 3), '0, '0, one_hot(i));
      next_cycle();
      issue_op(make_op(OPC_OR, 4'd0), '0, one_hot(i + 2), one_hot(i), '0);
    end
    drain();

    test_name = "back_to_back";
    repeat (24) begin
      next_cycle();
      r = rand_word();
      random_select(na, oa);
      random_select(nb, ob);
      issue_op(make_op(r[4] ? OPC_PERM : logic_ops[r[6:5]], r[3:0]), na, oa, nb, ob);
    end
    drain();

    test_name = "undefined_masked";
    fpcsr = rand_word();
    fpcsr[`FPL_CSR_INV_EN] = 1'b0;
    for (int k = 0; k < 6; k++) begin
      next_cycle();
      issue_op(make_op(bad_ops[k], 4'hf), '0, '0, '0, '0);
    end
    drain();

    test_name = "undefined_enabled";
    fpcsr = rand_word();
    fpcsr[`FPL_CSR_INV_EN] = 1'b1;
    for (int k = 0; k < 6; k++) begin
      next_cycle();
      issue_op(make_op(bad_ops[k], 4'hf), '0, '0, '0, '0);
      next_cycle();
      issue_op(make_op(OPC_AND, 4'd0), '0, '0, '0, '0);
    end
    drain();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fpu_lane.f ====
+incdir+source
source/fpu_lane_pkg.sv
source/operand_forward.sv
source/op_decoder.sv
source/logic_unit.sv
source/single_permute.sv
source/fpu_lane.sv
bench/clock_gen.sv
bench/fpu_lane_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module fpu_lane_tb -f fpu_lane.f

./obj_dir/Vfpu_lane_tb 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

// ==== source/fpu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_lane_settings.svh"

module fpu_lane
  import fpu_lane_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   en,
  input  wire op_t              op,
  input  wire operand_t         reg_a,
  input  wire operand_t         reg_b,
  input  wire fwd_sel_t         fwd_now_a,
  input  wire fwd_sel_t         fwd_old_a,
  input  wire fwd_sel_t         fwd_now_b,
  input  wire fwd_sel_t         fwd_old_b,
  input  wire operand_t         fwd_bus0,
  input  wire operand_t         fwd_bus1,
  input  wire operand_t         fwd_bus2,
  input  wire operand_t         fwd_bus3,
  input  wire [`FPL_RTAG_W-1:0] ret_tag,
  input  wire [31:0]            fpcsr,
  output operand_t              result,
  output logic                  ret_en,
  output ret_code_t             ret_code
);

  operand_t  opa;
  operand_t  opb;
  operand_t  opa_q;
  operand_t  opb_q;

  logic      logic_en;
  logic_fn_t logic_fn;
  logic      perm_en;
  logic      hi_from_a;
  logic      lo_from_a;
  logic      swap;
  logic      dup;

  operand_t  logic_res;
  operand_t  perm_res;

  operand_forward fwd_a (
    .clk     (clk),
    .rst     (rst),
    .reg_val (reg_a),
    .fwd_now (fwd_now_a),
    .fwd_old (fwd_old_a),
    .bus0    (fwd_bus0),
    .bus1    (fwd_bus1),
    .bus2    (fwd_bus2),
    .bus3    (fwd_bus3),
    .operand (opa)
  );

  operand_forward fwd_b (
    .clk     (clk),
    .rst     (rst),
    .reg_val (reg_b),
    .fwd_now (fwd_now_b),
    .fwd_old (fwd_old_b),
    .bus0    (fwd_bus0),
    .bus1    (fwd_bus1),
    .bus2    (fwd_bus2),
    .bus3    (fwd_bus3),
    .operand (opb)
  );

  // operands line up with the decoded controls in T+1
  always_ff @(posedge clk) begin
    opa_q <= opa;
    opb_q <= opb;
  end

  op_decoder decoder (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .op        (op),
    .ret_tag   (ret_tag),
    .fpcsr     (fpcsr),
    .logic_en  (logic_en),
    .logic_fn  (logic_fn),
    .perm_en   (perm_en),
    .hi_from_a (hi_from_a),
    .lo_from_a (lo_from_a),
    .swap      (swap),
    .dup       (dup),
    .ret_en    (ret_en),
    .ret_code  (ret_code)
  );

  logic_unit logic_dp (
    .clk (clk),
    .rst (rst),
    .en  (logic_en),
    .fn  (logic_fn),
    .a   (opa_q),
    .b   (opb_q),
    .res (logic_res)
  );

  single_permute perm_dp (
    .clk       (clk),
    .rst       (rst),
    .en        (perm_en),
    .hi_from_a (hi_from_a),
    .lo_from_a (lo_from_a),
    .swap      (swap),
    .dup       (dup),
    .a         (opa_q),
    .b         (opb_q),
    .res       (perm_res)
  );

  // at most one datapath is enabled, the other holds zero
  assign result = logic_res | perm_res;

endmodule

`default_nettype wire

// ==== source/fpu_lane_pkg.sv ====
`default_nettype none

`include "fpu_lane_settings.svh"

package fpu_lane_pkg;

  typedef logic [`FPL_DATA_W-1:0] operand_t;

  // swap, hi-from-a, lo-from-a sit just above the opcode byte
  typedef struct packed {
    logic                   dup;
    logic                   rsv;
    logic                   swap;
    logic                   hi_from_a;
    logic                   lo_from_a;
    logic [`FPL_OP_W-6:0]   opcode;
  } op_t;

  // one-hot, bit i picks result bus i
  typedef logic [`FPL_NFWD-1:0] fwd_sel_t;

  typedef enum logic [1:0] {
    FN_AND    = 2'd0,
    FN_OR     = 2'd1,
    FN_XOR    = 2'd2,
    FN_ANDNOT = 2'd3
  } logic_fn_t;

  localparam int RET_FLAG_W = `FPL_RET_W - 1 - `FPL_RTAG_W;

  // flags hold raised conditions before masking, bit 0 is invalid
  typedef struct packed {
    logic                   excpt;
    logic [RET_FLAG_W-1:0]  flags;
    logic [`FPL_RTAG_W-1:0] tag;
  } ret_code_t;

endpackage

`default_nettype wire

// ==== source/fpu_lane_settings.svh ====
`ifndef FPU_LANE_SETTINGS_SVH
`define FPU_LANE_SETTINGS_SVH

// operand layout, class tag above a 64-bit value
`define FPL_DATA_W 68
`define FPL_VAL_W 64
`define FPL_TAG_W 4

// issued op and retire widths
`define FPL_OP_W 13
`define FPL_RTAG_W 9
`define FPL_RET_W 14

// result buses seen by the bypass
`define FPL_NFWD 4

// opcodes; low two bits of the logic group pick the function
`define FPL_OPC_LOGIC 8'h40
`define FPL_OPC_PERM 8'h48

// invalid-exception enable in fpcsr
`define FPL_CSR_INV_EN 11

`endif

// ==== source/logic_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_lane_settings.svh"

module logic_unit
  import fpu_lane_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            en,
  input  wire logic_fn_t fn,
  input  wire operand_t  a,
  input  wire operand_t  b,
  output operand_t       res
);

  logic [`FPL_VAL_W-1:0] val;

  always_comb begin
    case (fn)
      FN_AND:    val = a[`FPL_VAL_W-1:0] & b[`FPL_VAL_W-1:0];
      FN_OR:     val = a[`FPL_VAL_W-1:0] | b[`FPL_VAL_W-1:0];
      FN_XOR:    val = a[`FPL_VAL_W-1:0] ^ b[`FPL_VAL_W-1:0];
      default:   val = a[`FPL_VAL_W-1:0] & ~b[`FPL_VAL_W-1:0];
    endcase
  end

  // idle cycles hold zero so the top can OR results
  always_ff @(posedge clk) begin
    if (rst) begin
      res <= '0;
    end else if (en) begin
      res <= {a[`FPL_DATA_W-1 -: `FPL_TAG_W], val};
    end else begin
      res <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_lane_settings.svh"

module op_decoder
  import fpu_lane_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   en,
  input  wire op_t              op,
  input  wire [`FPL_RTAG_W-1:0] ret_tag,
  input  wire [31:0]            fpcsr,
  output logic                  logic_en,
  output logic_fn_t             logic_fn,
  output logic                  perm_en,
  output logic                  hi_from_a,
  output logic                  lo_from_a,
  output logic                  swap,
  output logic                  dup,
  output logic                  ret_en,
  output ret_code_t             ret_code
);

  // issue stage, valid during T+1
  logic                   en_q;
  op_t                    op_q;
  logic [`FPL_RTAG_W-1:0] tag_q;

  // retire stage, valid during T+2
  logic                   ret_vld_q;
  logic                   inv_q;
  logic [`FPL_RTAG_W-1:0] ret_tag_q;

  logic is_logic;
  logic is_perm;
  logic invalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
    end else begin
      en_q <= en;
    end
  end

  always_ff @(posedge clk) begin
    op_q  <= op;
    tag_q <= ret_tag;
  end

  assign is_logic = {op_q.opcode[7:2], 2'b00} == `FPL_OPC_LOGIC;
  assign is_perm  = op_q.opcode == `FPL_OPC_PERM;

  // anything outside the two groups is undefined
  assign invalid = en_q & ~is_logic & ~is_perm;

  assign logic_en  = en_q & is_logic;
  assign logic_fn  = logic_fn_t'(op_q.opcode[1:0]);
  assign perm_en   = en_q & is_perm;
  assign hi_from_a = op_q.hi_from_a;
  assign lo_from_a = op_q.lo_from_a;
  assign swap      = op_q.swap;
  assign dup       = op_q.dup;

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_vld_q <= 1'b0;
      inv_q     <= 1'b0;
    end else begin
      ret_vld_q <= en_q;
      inv_q     <= invalid;
    end
  end

  always_ff @(posedge clk) begin
    ret_tag_q <= tag_q;
  end

  // enable bit is read in the retire cycle itself
  assign ret_en         = ret_vld_q;
  assign ret_code.excpt = inv_q & fpcsr[`FPL_CSR_INV_EN];
  assign ret_code.flags = {{(RET_FLAG_W-1){1'b0}}, inv_q};
  assign ret_code.tag   = ret_tag_q;

endmodule

`default_nettype wire

// ==== source/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_lane_settings.svh"

module operand_forward
  import fpu_lane_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire operand_t  reg_val,
  input  wire fwd_sel_t  fwd_now,
  input  wire fwd_sel_t  fwd_old,
  input  wire operand_t  bus0,
  input  wire operand_t  bus1,
  input  wire operand_t  bus2,
  input  wire operand_t  bus3,
  output operand_t       operand
);

  operand_t bus_now [`FPL_NFWD];
  operand_t bus_old [`FPL_NFWD];

  assign bus_now[0] = bus0;
  assign bus_now[1] = bus1;
  assign bus_now[2] = bus2;
  assign bus_now[3] = bus3;

  // copy of every bus as it was at the last edge
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FPL_NFWD; i++) begin
        bus_old[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `FPL_NFWD; i++) begin
        bus_old[i] <= bus_now[i];
      end
    end
  end

  // current-cycle bypass wins over the registered one
  always_comb begin
    operand = reg_val;
    if (|fwd_now) begin
      for (int i = 0; i < `FPL_NFWD; i++) begin
        if (fwd_now[i]) begin
          operand = bus_now[i];
        end
      end
    end else if (|fwd_old) begin
      for (int i = 0; i < `FPL_NFWD; i++) begin
        if (fwd_old[i]) begin
          operand = bus_old[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/single_permute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_lane_settings.svh"

module single_permute
  import fpu_lane_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire           en,
  input  wire           hi_from_a,
  input  wire           lo_from_a,
  input  wire           swap,
  input  wire           dup,
  input  wire operand_t a,
  input  wire operand_t b,
  output operand_t      res
);

  localparam int SNG_W = `FPL_VAL_W / 2;

  logic [SNG_W-1:0] sel_lo;
  logic [SNG_W-1:0] sel_hi;
  logic [SNG_W-1:0] swp_lo;
  logic [SNG_W-1:0] swp_hi;
  logic [SNG_W-1:0] out_hi;

  // select, then swap, then duplicate
  assign sel_lo = lo_from_a ? a[SNG_W-1:0] : b[SNG_W-1:0];
  assign sel_hi = hi_from_a ? a[`FPL_VAL_W-1:SNG_W] : b[`FPL_VAL_W-1:SNG_W];

  assign swp_lo = swap ? sel_hi : sel_lo;
  assign swp_hi = swap ? sel_lo : sel_hi;

  assign out_hi = dup ? swp_lo : swp_hi;

  always_ff @(posedge clk) begin
    if (rst) begin
      res <= '0;
    end else if (en) begin
      res <= {a[`FPL_DATA_W-1 -: `FPL_TAG_W], out_hi, swp_lo};
    end else begin
      res <= '0;
    end
  end

endmodule

`default_nettype wire
